/* fpMul.f */
rtl/fpMulPkg.sv
rtl/boothMantMul.sv
rtl/fpStageRegs.sv
rtl/fpRoundPack.sv
rtl/fpMul.sv
bench/fpMul_props.sv
bench/fpMulTb.sv

/* bench/fpMulTb.sv */
module fpMulTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 4;
    localparam int RAND_COUNT   = 16;
    localparam int LATENCY      = 3;
    localparam int MARGIN       = 20;

    typedef struct {
        string           name;
        fpMulPkg::fp32T  x;
        fpMulPkg::fp32T  y;
        fpMulPkg::rModeT mode;
        fpMulPkg::fp32T  z;
        logic            ovf;
        logic            udf;
        int              issued;
    } vecT;

    logic            clk;
    logic            arstN;
    logic            inValid;
    fpMulPkg::fp32T  fpX;
    fpMulPkg::fp32T  fpY;
    fpMulPkg::rModeT rMode;
    logic            outValid;
    fpMulPkg::fp32T  fpZ;
    logic            ovrf;
    logic            udrf;

    vecT vecTable[$];
    vecT pending[$];
    int  cycleCount = 0;
    int  cycleLimit;

    fpMul u_fpMul (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .fpX      (fpX),
        .fpY      (fpY),
        .rMode    (rMode),
        .outValid (outValid),
        .fpZ      (fpZ),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abortRun();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkVal(input string testName, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("** Error %s: expected %h, actual %h", testName, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic addEntry(input string name, input fpMulPkg::fp32T x,
                            input fpMulPkg::fp32T y, input fpMulPkg::rModeT mode,
                            input fpMulPkg::fp32T z, input logic ovf, input logic udf);
        vecT e;
        e.name   = name;
        e.x      = x;
        e.y      = y;
        e.mode   = mode;
        e.z      = z;
        e.ovf    = ovf;
        e.udf    = udf;
        e.issued = 0;
        vecTable.push_back(e);
    endtask

    task automatic buildTable();
        // Exact products
        addEntry("1.5 x 2.0", 32'h3FC0_0000, 32'h4000_0000, 3'd0, 32'h4040_0000, 0, 0);
        addEntry("-1.5 x 1.5", 32'hBFC0_0000, 32'h3FC0_0000, 3'd0, 32'hC010_0000, 0, 0);
        // Halfway cases around an even kept significand
        addEntry("tie RNE", 32'h3F80_0003, 32'h3FC0_0000, 3'd0, 32'h3FC0_0004, 0, 0);
        addEntry("tie RMM", 32'h3F80_0003, 32'h3FC0_0000, 3'd4, 32'h3FC0_0005, 0, 0);
        addEntry("tie RTZ", 32'h3F80_0003, 32'h3FC0_0000, 3'd1, 32'h3FC0_0004, 0, 0);
        addEntry("tie RUP", 32'h3F80_0003, 32'h3FC0_0000, 3'd3, 32'h3FC0_0005, 0, 0);
        addEntry("tie RDN", 32'h3F80_0003, 32'h3FC0_0000, 3'd2, 32'h3FC0_0004, 0, 0);
        addEntry("neg tie RUP", 32'hBF80_0003, 32'h3FC0_0000, 3'd3, 32'hBFC0_0004, 0, 0);
        addEntry("neg tie RDN", 32'hBF80_0003, 32'h3FC0_0000, 3'd2, 32'hBFC0_0005, 0, 0);
        // Zero and subnormal operands
        addEntry("+0 x 1.5", 32'h0000_0000, 32'h3FC0_0000, 3'd0, 32'h0000_0000, 0, 0);
        addEntry("-0 x 2.0", 32'h8000_0000, 32'h4000_0000, 3'd1, 32'h8000_0000, 0, 0);
        addEntry("sub x -2.0", 32'h0000_0001, 32'hC000_0000, 3'd2, 32'h8000_0000, 0, 0);
        addEntry("-sub x -1.0", 32'h8040_0000, 32'hBF80_0000, 3'd3, 32'h0000_0000, 0, 0);
        addEntry("1.0 x -0", 32'h3F80_0000, 32'h8000_0000, 3'd4, 32'h8000_0000, 0, 0);
        // Special classes
        addEntry("inf x -2.0", 32'h7F80_0000, 32'hC000_0000, 3'd0, 32'hFF80_0000, 0, 0);
        addEntry("inf x 0", 32'h7F80_0000, 32'h0000_0000, 3'd0, 32'h7FC0_0000, 0, 0);
        addEntry("nan x 1.0", 32'h7FC0_0001, 32'h3F80_0000, 3'd0, 32'h7FC0_0000, 0, 0);
        addEntry("-inf x -inf", 32'hFF80_0000, 32'hFF80_0000, 3'd1, 32'h7F80_0000, 0, 0);
        // Overflow where the exponent sum reaches 255
        addEntry("ovf RNE", 32'h7F00_0000, 32'h4000_0000, 3'd0, 32'h7F80_0000, 1, 0);
        addEntry("ovf RTZ", 32'h7F00_0000, 32'h4000_0000, 3'd1, 32'h7F7F_FFFF, 1, 0);
        addEntry("neg ovf RUP", 32'hFF00_0000, 32'h4000_0000, 3'd3, 32'hFF7F_FFFF, 1, 0);
        addEntry("neg ovf RDN", 32'hFF00_0000, 32'h4000_0000, 3'd2, 32'hFF80_0000, 1, 0);
        // Result exponent of zero is flushed
        addEntry("udf", 32'h0080_0000, 32'h3F00_0000, 3'd0, 32'h0000_0000, 0, 1);
    endtask

    // Drive one operation for a single cycle
    task automatic driveEntry(input vecT e);
        inValid  = 1'b1;
        fpX      = e.x;
        fpY      = e.y;
        rMode    = e.mode;
        e.issued = cycleCount;
        pending.push_back(e);
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, %0d results still outstanding",
                     cycleCount, pending.size());
            abortRun();
        end
    end

    // Outputs are sampled at the falling edge
    always @(negedge clk) begin
        vecT expEntry;
        if (u_fpMul.u_props.failCount != 0) begin
            $display("A bound assertion failed during the run");
            abortRun();
        end else if (arstN && outValid) begin
            if (pending.size() == 0) begin
                $display("outValid went high with no operation outstanding");
                abortRun();
            end else begin
                expEntry = pending.pop_front();
                checkVal({expEntry.name, " latency"}, LATENCY, cycleCount - expEntry.issued);
                checkVal({expEntry.name, " fpZ"}, expEntry.z, fpZ);
                checkVal({expEntry.name, " ovrf"}, expEntry.ovf, ovrf);
                checkVal({expEntry.name, " udrf"}, expEntry.udf, udrf);
            end
        end
    end

    initial begin
        vecT entry;
        void'($urandom(93002));
        arstN   = 1'b0;
        inValid = 1'b0;
        fpX     = '0;
        fpY     = '0;
        rMode   = fpMulPkg::RM_RNE;
        buildTable();
        cycleLimit = RESET_CYCLES + vecTable.size() + RAND_COUNT + LATENCY + MARGIN;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkVal("reset outValid", 0, outValid);
            checkVal("reset fpZ", 0, fpZ);
            checkVal("reset ovrf", 0, ovrf);
            checkVal("reset udrf", 0, udrf);
        end
        arstN = 1'b1;
        @(negedge clk);
        checkVal("idle outValid", 0, outValid);
        checkVal("idle ovrf", 0, ovrf);
        checkVal("idle udrf", 0, udrf);

        // Back to back so that three operations are in flight
        foreach (vecTable[i]) begin
            driveEntry(vecTable[i]);
        end

        // Both operands with a zero exponent field
        for (int i = 0; i < RAND_COUNT; i++) begin
            entry.name        = $sformatf("random subnormal %0d", i);
            entry.x           = $urandom;
            entry.x[30:23]    = 8'h00;
            entry.y           = $urandom;
            entry.y[30:23]    = 8'h00;
            entry.mode        = $urandom % 8;
            entry.z           = {entry.x[31] ^ entry.y[31], 31'd0};
            entry.ovf         = 1'b0;
            entry.udf         = 1'b0;
            driveEntry(entry);
        end
        inValid = 1'b0;

        while (pending.size() != 0) begin
            @(negedge clk);
        end

        // The bound checker looks at the last result one rising edge later
        @(negedge clk);

        if (u_fpMul.u_props.failCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures", u_fpMul.u_props.failCount);
            abortRun();
        end
    end

endmodule

/* bench/fpMul_props.sv */
module fpMul_props (
    input logic            clk,
    input logic            arstN,
    input logic            inValid,
    input fpMulPkg::fp32T  fpX,
    input fpMulPkg::fp32T  fpY,
    input logic            outValid,
    input fpMulPkg::fp32T  fpZ,
    input logic            ovrf,
    input logic            udrf,
    input fpMulPkg::prodT  pProduct
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // Operand history, xD3 lines up with outValid
    fpMulPkg::fp32T xD1;
    fpMulPkg::fp32T xD2;
    fpMulPkg::fp32T xD3;
    fpMulPkg::fp32T yD1;
    fpMulPkg::fp32T yD2;
    fpMulPkg::fp32T yD3;

    always @(posedge clk) begin
        xD1 <= fpX;
        xD2 <= xD1;
        xD3 <= xD2;
        yD1 <= fpY;
        yD2 <= yD1;
        yD3 <= yD2;
    end

    // Zero or subnormal X times a non-special Y
    zeroXChk: assert property (@(posedge clk) disable iff (!arstN)
        outValid && (xD3[30:23] == 8'h00) && (yD3[30:23] != 8'hFF)
        |-> (fpZ == {xD3[31] ^ yD3[31], 31'd0}) && !ovrf && !udrf)
    else begin
        $error("Zero X operand did not give a signed zero");
        failCount++;
    end

    // Same rule with the operands swapped
    zeroYChk: assert property (@(posedge clk) disable iff (!arstN)
        outValid && (yD3[30:23] == 8'h00) && (xD3[30:23] != 8'hFF)
        |-> (fpZ == {xD3[31] ^ yD3[31], 31'd0}) && !ovrf && !udrf)
    else begin
        $error("Zero Y operand did not give a signed zero");
        failCount++;
    end

    // Booth sum against the plain significand product
    boothChk: assert property (@(posedge clk) disable iff (!arstN)
        inValid |=> (pProduct == ({24'd0, 1'b1, xD1[22:0]} * {24'd0, 1'b1, yD1[22:0]})))
    else begin
        $error("Booth product differs from the significand product");
        failCount++;
    end

    resetChk: assert property (@(posedge clk) !arstN |-> !outValid)
    else begin
        $error("outValid high during reset");
        failCount++;
    end

endmodule

bind fpMul fpMul_props u_props (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .fpX      (fpX),
    .fpY      (fpY),
    .outValid (outValid),
    .fpZ      (fpZ),
    .ovrf     (ovrf),
    .udrf     (udrf),
    .pProduct (pProduct)
);

/* rtl/fpMul.sv */
module fpMul (
    input  logic            clk,
    input  logic            arstN,
    input  logic            inValid,
    input  fpMulPkg::fp32T  fpX,
    input  fpMulPkg::fp32T  fpY,
    input  fpMulPkg::rModeT rMode,
    output logic            outValid,
    output fpMulPkg::fp32T  fpZ,
    output logic            ovrf,
    output logic            udrf
);

    // Producer to buffer
    logic             pValid;
    logic             pSign;
    fpMulPkg::expSumT pExpSum;
    fpMulPkg::prodT   pProduct;
    fpMulPkg::classT  pClass;
    fpMulPkg::rModeT  pRMode;

    // Buffer to consumer
    logic             bValid;
    logic             bSign;
    fpMulPkg::expSumT bExpSum;
    fpMulPkg::prodT   bProduct;
    fpMulPkg::classT  bClass;
    fpMulPkg::rModeT  bRMode;

    boothMantMul u_producer (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .fpX      (fpX),
        .fpY      (fpY),
        .rMode    (rMode),
        .pValid   (pValid),
        .pSign    (pSign),
        .pExpSum  (pExpSum),
        .pProduct (pProduct),
        .pClass   (pClass),
        .pRMode   (pRMode)
    );

    fpStageRegs u_buffer (
        .clk      (clk),
        .arstN    (arstN),
        .pValid   (pValid),
        .pSign    (pSign),
        .pExpSum  (pExpSum),
        .pProduct (pProduct),
        .pClass   (pClass),
        .pRMode   (pRMode),
        .bValid   (bValid),
        .bSign    (bSign),
        .bExpSum  (bExpSum),
        .bProduct (bProduct),
        .bClass   (bClass),
        .bRMode   (bRMode)
    );

    fpRoundPack u_consumer (
        .clk      (clk),
        .arstN    (arstN),
        .bValid   (bValid),
        .bSign    (bSign),
        .bExpSum  (bExpSum),
        .bProduct (bProduct),
        .bClass   (bClass),
        .bRMode   (bRMode),
        .outValid (outValid),
        .fpZ      (fpZ),
        .ovrf     (ovrf),
        .udrf     (udrf)
    );

endmodule

/* rtl/fpRoundPack.sv */
module fpRoundPack (
    input  logic             clk,
    input  logic             arstN,
    input  logic             bValid,
    input  logic             bSign,
    input  fpMulPkg::expSumT bExpSum,
    input  fpMulPkg::prodT   bProduct,
    input  fpMulPkg::classT  bClass,
    input  fpMulPkg::rModeT  bRMode,
    output logic             outValid,
    output fpMulPkg::fp32T   fpZ,
    output logic             ovrf,
    output logic             udrf
);

    fpMulPkg::mantT   normMant;
    fpMulPkg::expSumT normExp;
    logic             guardBit;
    logic             stickyBit;
    logic             rneInc;
    logic             roundInc;
    logic [24:0]      mantRnd;
    fpMulPkg::fracT   fracFinal;
    fpMulPkg::expSumT expFinal;
    logic             ovfToInf;
    logic             ovfDet;
    logic             udfDet;
    fpMulPkg::fp32T   zNext;
    logic             ovrfNext;
    logic             udrfNext;

    // Product lies in [1, 4), bit 47 means one extra exponent step
    always_comb begin
        if (bProduct[47]) begin
            normMant  = bProduct[47:24];
            guardBit  = bProduct[23];
            stickyBit = |bProduct[22:0];
            normExp   = bExpSum + 10'sd1;
        end else begin
            normMant  = bProduct[46:23];
            guardBit  = bProduct[22];
            stickyBit = |bProduct[21:0];
            normExp   = bExpSum;
        end
    end

    assign rneInc = guardBit & (stickyBit | normMant[0]);

    always_comb begin
        case (bRMode)
            fpMulPkg::RM_RNE: roundInc = rneInc;
            fpMulPkg::RM_RTZ: roundInc = 1'b0;
            fpMulPkg::RM_RDN: roundInc = bSign & (guardBit | stickyBit);
            fpMulPkg::RM_RUP: roundInc = !bSign & (guardBit | stickyBit);
            fpMulPkg::RM_RMM: roundInc = guardBit;
            default:          roundInc = rneInc;
        endcase
    end

    assign mantRnd = {1'b0, normMant} + {24'd0, roundInc};

    // Carry out of rounding leaves 1.0, so the fraction is all zero
    assign fracFinal = mantRnd[24] ? mantRnd[23:1] : mantRnd[22:0];
    assign expFinal  = mantRnd[24] ? normExp + 10'sd1 : normExp;

    assign ovfDet = (expFinal >= 10'sd255);
    assign udfDet = (expFinal <= 10'sd0);

    // Overflow goes to infinity unless the mode rounds toward the finite side
    always_comb begin
        case (bRMode)
            fpMulPkg::RM_RTZ: ovfToInf = 1'b0;
            fpMulPkg::RM_RDN: ovfToInf = bSign;
            fpMulPkg::RM_RUP: ovfToInf = !bSign;
            default:          ovfToInf = 1'b1;
        endcase
    end

    always_comb begin
        ovrfNext = 1'b0;
        udrfNext = 1'b0;
        case (bClass)
            fpMulPkg::CL_ZERO: begin
                zNext = {bSign, 31'd0};
            end
            fpMulPkg::CL_INF: begin
                zNext = {bSign, 8'hFF, 23'd0};
            end
            fpMulPkg::CL_NAN: begin
                zNext = fpMulPkg::QNAN;
            end
            default: begin
                if (ovfDet) begin
                    ovrfNext = 1'b1;
                    if (ovfToInf) begin
                        zNext = {bSign, 8'hFF, 23'd0};
                    end else begin
                        zNext = {bSign, 8'hFE, {23{1'b1}}};
                    end
                end else if (udfDet) begin
                    // No gradual underflow, flush to signed zero
                    udrfNext = 1'b1;
                    zNext    = {bSign, 31'd0};
                end else begin
                    zNext = {bSign, expFinal[7:0], fracFinal};
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            fpZ      <= '0;
            ovrf     <= 1'b0;
            udrf     <= 1'b0;
        end else begin
            outValid <= bValid;
            if (bValid) begin
                fpZ  <= zNext;
                ovrf <= ovrfNext;
                udrf <= udrfNext;
            end
        end
    end

endmodule

/* rtl/fpStageRegs.sv */
module fpStageRegs (
    input  logic             clk,
    input  logic             arstN,
    input  logic             pValid,
    input  logic             pSign,
    input  fpMulPkg::expSumT pExpSum,
    input  fpMulPkg::prodT   pProduct,
    input  fpMulPkg::classT  pClass,
    input  fpMulPkg::rModeT  pRMode,
    output logic             bValid,
    output logic             bSign,
    output fpMulPkg::expSumT bExpSum,
    output fpMulPkg::prodT   bProduct,
    output fpMulPkg::classT  bClass,
    output fpMulPkg::rModeT  bRMode
);

    // Control part of the stage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bValid <= 1'b0;
            bClass <= fpMulPkg::CL_NORMAL;
        end else begin
            bValid <= pValid;
            if (pValid) begin
                bClass <= pClass;
            end
        end
    end

    // Data holds its last value on idle cycles
    always_ff @(posedge clk) begin
        if (pValid) begin
            bSign    <= pSign;
            bExpSum  <= pExpSum;
            bProduct <= pProduct;
            bRMode   <= pRMode;
        end
    end

endmodule

/* rtl/boothMantMul.sv */
module boothMantMul (
    input  logic             clk,
    input  logic             arstN,
    input  logic             inValid,
    input  fpMulPkg::fp32T   fpX,
    input  fpMulPkg::fp32T   fpY,
    input  fpMulPkg::rModeT  rMode,
    output logic             pValid,
    output logic             pSign,
    output fpMulPkg::expSumT pExpSum,
    output fpMulPkg::prodT   pProduct,
    output fpMulPkg::classT  pClass,
    output fpMulPkg::rModeT  pRMode
);

    fpMulPkg::expT    xExp;
    fpMulPkg::expT    yExp;
    fpMulPkg::fracT   xFrac;
    fpMulPkg::fracT   yFrac;
    fpMulPkg::mantT   xMant;
    fpMulPkg::prodT   xMantExt;
    logic             xZero;
    logic             xInf;
    logic             xNan;
    logic             yZero;
    logic             yInf;
    logic             yNan;
    fpMulPkg::classT  opClass;
    fpMulPkg::expSumT expSum;
    logic [24:0]      yRecode;
    fpMulPkg::prodT   partProd [12];
    fpMulPkg::prodT   prodSum;

    assign xExp  = fpX[30:23];
    assign yExp  = fpY[30:23];
    assign xFrac = fpX[22:0];
    assign yFrac = fpY[22:0];

    // Subnormals count as zeros
    assign xZero = (xExp == 8'h00);
    assign yZero = (yExp == 8'h00);
    assign xInf  = (xExp == 8'hFF) && (xFrac == '0);
    assign yInf  = (yExp == 8'hFF) && (yFrac == '0);
    assign xNan  = (xExp == 8'hFF) && (xFrac != '0);
    assign yNan  = (yExp == 8'hFF) && (yFrac != '0);

    always_comb begin
        if (xNan || yNan || (xInf && yZero) || (yInf && xZero)) begin
            opClass = fpMulPkg::CL_NAN;
        end else if (xInf || yInf) begin
            opClass = fpMulPkg::CL_INF;
        end else if (xZero || yZero) begin
            opClass = fpMulPkg::CL_ZERO;
        end else begin
            opClass = fpMulPkg::CL_NORMAL;
        end
    end

    // Biased exponent of the product before normalization
    assign expSum = $signed({2'b00, xExp}) + $signed({2'b00, yExp}) - fpMulPkg::EXP_BIAS;

    assign xMant    = {1'b1, xFrac};
    assign xMantExt = {24'd0, xMant};

    // Booth windows over the zero-extended fraction of Y, appended zero below
    assign yRecode = {1'b0, yFrac, 1'b0};

    always_comb begin
        prodSum = '0;
        for (int i = 0; i < 12; i++) begin
            case (yRecode[2*i +: 3])
                3'b001, 3'b010: partProd[i] = xMantExt << (2 * i);
                3'b011:         partProd[i] = xMantExt << (2 * i + 1);
                3'b100:         partProd[i] = -(xMantExt << (2 * i + 1));
                3'b101, 3'b110: partProd[i] = -(xMantExt << (2 * i));
                default:        partProd[i] = '0;
            endcase
            prodSum = prodSum + partProd[i];
        end
        // Hidden bit of Y weighs 2^23
        prodSum = prodSum + (xMantExt << 23);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pValid <= 1'b0;
            pClass <= fpMulPkg::CL_NORMAL;
        end else begin
            pValid <= inValid;
            if (inValid) begin
                pClass <= opClass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            pSign    <= fpX[31] ^ fpY[31];
            pExpSum  <= expSum;
            pProduct <= prodSum;
            pRMode   <= rMode;
        end
    end

endmodule

/* rtl/fpMulPkg.sv */
package fpMulPkg;

    // Field and datapath widths of the single-precision format
    typedef logic        [31:0] fp32T;
    typedef logic        [7:0]  expT;
    typedef logic signed [9:0]  expSumT;
    typedef logic        [22:0] fracT;
    typedef logic        [23:0] mantT;
    typedef logic        [47:0] prodT;
    typedef logic        [2:0]  rModeT;
    typedef logic        [1:0]  classT;

    localparam expSumT EXP_BIAS = 10'sd127;

    // Canonical quiet NaN
    localparam fp32T QNAN = 32'h7FC0_0000;

    // Rounding modes, unknown codes fall back to nearest-even
    localparam rModeT RM_RNE = 3'b000;
    localparam rModeT RM_RTZ = 3'b001;
    localparam rModeT RM_RDN = 3'b010;
    localparam rModeT RM_RUP = 3'b011;
    localparam rModeT RM_RMM = 3'b100;

    // Special class of an operation
    localparam classT CL_NORMAL = 2'b00;
    localparam classT CL_ZERO   = 2'b01;
    localparam classT CL_INF    = 2'b10;
    localparam classT CL_NAN    = 2'b11;

endpackage
